/* build.f */
+incdir+common
common/cce_inst_pkg.sv
common/cce_msg_pkg.sv
ctrl/cce_ctrl.sv
design/cce_alu_branch.sv
design/cce_regs.sv
design/cce_pending.sv
design/cce_msg.sv
design/cce_top.sv
verif/cce_tb.sv

/* common/cce_config.svh */
// Fixed engine sizes; GPR must be at least as wide as a message word and hold a full address
`ifndef CCE_CONFIG_SVH
`define CCE_CONFIG_SVH

// Microcode store of 64 instructions
`define CCE_PC_WIDTH 6
`define CCE_INST_WIDTH 32

// General purpose registers
`define CCE_GPR_WIDTH 16
`define CCE_NUM_GPR 4
`define CCE_GPR_SEL_WIDTH 2

// Block address and pending table geometry
`define CCE_ADDR_WIDTH 12
`define CCE_LG_WAY_GROUPS 3
// Way group index starts above these bits
`define CCE_BLOCK_OFFSET 2

`endif

/* common/cce_inst_pkg.sv */
// Instruction encodings; both formats must stay exactly CCE_INST_WIDTH bits so the union lines up
`default_nettype none

`include "cce_config.svh"

package cce_inst_pkg;

  typedef enum logic [3:0] {
    e_op_add   = 4'h0,
    e_op_sub   = 4'h1,
    e_op_and   = 4'h2,
    e_op_or    = 4'h3,
    e_op_shr   = 4'h4,
    e_op_movi  = 4'h5,
    e_op_beq   = 4'h6,
    e_op_bne   = 4'h7,
    e_op_blt   = 4'h8,
    e_op_jmp   = 4'h9,
    e_op_popq  = 4'ha,
    e_op_pushc = 4'hb,
    e_op_pset  = 4'hc,
    e_op_pclr  = 4'hd,
    e_op_prd   = 4'he,
    e_op_nop   = 4'hf
  } cce_opcode_e;

  // Unused low bits of each format
  localparam int op_pad_width = `CCE_INST_WIDTH - 4 - 3 * `CCE_GPR_SEL_WIDTH - 1 - `CCE_GPR_WIDTH;
  localparam int br_pad_width = `CCE_INST_WIDTH - 4 - 2 * `CCE_GPR_SEL_WIDTH - 1 - `CCE_PC_WIDTH;

  // ALU, message and pending-bit operations
  typedef struct packed {
    cce_opcode_e                    opcode;
    logic [`CCE_GPR_SEL_WIDTH-1:0]  dst;
    logic [`CCE_GPR_SEL_WIDTH-1:0]  src_a;
    logic [`CCE_GPR_SEL_WIDTH-1:0]  src_b;
    logic                           use_imm;
    logic [`CCE_GPR_WIDTH-1:0]      imm;
    logic [op_pad_width-1:0]        pad;
  } cce_inst_op_s;

  // Conditional branches and JMP
  typedef struct packed {
    cce_opcode_e                    opcode;
    logic [`CCE_GPR_SEL_WIDTH-1:0]  src_a;
    logic [`CCE_GPR_SEL_WIDTH-1:0]  src_b;
    logic                           predict_taken;
    logic [`CCE_PC_WIDTH-1:0]       target;
    logic [br_pad_width-1:0]        pad;
  } cce_inst_br_s;

  // Opcode sits in the same bits of both views
  typedef union packed {
    cce_inst_op_s op;
    cce_inst_br_s br;
  } cce_inst_u;

endpackage

`default_nettype wire

/* common/cce_msg_pkg.sv */
// LCE message layouts; lce_id is fixed at 2 bits so each message fits one 16-bit GPR
`default_nettype none

`include "cce_config.svh"

package cce_msg_pkg;

  typedef enum logic [1:0] {
    e_req_read    = 2'd0,
    e_req_write   = 2'd1,
    e_req_upgrade = 2'd2,
    e_req_evict   = 2'd3
  } cce_req_type_e;

  typedef enum logic [1:0] {
    e_cmd_grant_s = 2'd0,
    e_cmd_grant_e = 2'd1,
    e_cmd_inval   = 2'd2,
    e_cmd_nack    = 2'd3
  } cce_cmd_type_e;

  typedef struct packed {
    cce_req_type_e               req_type;
    logic [1:0]                  lce_id;
    logic [`CCE_ADDR_WIDTH-1:0]  addr;
  } cce_lce_req_s;

  typedef struct packed {
    cce_cmd_type_e               cmd_type;
    logic [1:0]                  lce_id;
    logic [`CCE_ADDR_WIDTH-1:0]  addr;
  } cce_lce_cmd_s;

endpackage

`default_nettype wire

/* ctrl/cce_ctrl.sv */
// Fetch and execute control; RAM port goes to readback when cfg_run_i is low, writes are never blocked
`default_nettype none

`include "cce_config.svh"

module cce_ctrl
  import cce_inst_pkg::*;
  (input  wire                          clk_i
   , input  wire                        rst_i

   , input  wire                        cfg_run_i
   , input  wire                        cfg_w_v_i
   , input  wire [`CCE_PC_WIDTH-1:0]    cfg_addr_i
   , input  wire [`CCE_INST_WIDTH-1:0]  cfg_data_i

   , input  wire                        mispredict_i
   , input  wire [`CCE_PC_WIDTH-1:0]    branch_pc_i
   , input  wire                        pop_stall_i
   , input  wire                        push_stall_i

   , output logic [`CCE_INST_WIDTH-1:0] cfg_ucode_data_o
   , output cce_inst_u                  inst_o
   , output logic                       inst_v_o
   , output logic [`CCE_PC_WIDTH-1:0]   ex_pc_o
   );

  logic [`CCE_INST_WIDTH-1:0] ucode_ram [2**`CCE_PC_WIDTH];
  logic [`CCE_INST_WIDTH-1:0] ram_rd_data;
  logic [`CCE_PC_WIDTH-1:0]   ram_rd_addr;

  // Fetch stage RAM output and the PC it came from
  cce_inst_u                  fetch_inst;
  logic [`CCE_PC_WIDTH-1:0]   fetch_pc_r;
  logic                       fetch_v_r;
  logic                       predict_taken;
  logic [`CCE_PC_WIDTH-1:0]   predicted_pc;
  logic [`CCE_PC_WIDTH-1:0]   next_pc;

  // Execute stage
  cce_inst_u                  ex_inst_r;
  logic [`CCE_PC_WIDTH-1:0]   ex_pc_r;
  logic                       ex_v_r;
  logic                       stall;

  assign stall      = pop_stall_i | push_stall_i;
  assign fetch_inst = cce_inst_u'(ram_rd_data);

  // Static predecode of the fetched word
  always_comb begin
    case (fetch_inst.br.opcode)
      e_op_jmp: predict_taken = 1'b1;
      e_op_beq, e_op_bne, e_op_blt: predict_taken = fetch_inst.br.predict_taken;
      default: predict_taken = 1'b0;
    endcase
  end

  assign predicted_pc = predict_taken ? fetch_inst.br.target
                                      : fetch_pc_r + `CCE_PC_WIDTH'(1);

  // Redirect goes straight to the RAM, so the correct path executes two cycles after the branch
  always_comb begin
    if (mispredict_i) begin
      next_pc = branch_pc_i;
    end else if (stall || !fetch_v_r) begin
      // Re-read the same word
      next_pc = fetch_pc_r;
    end else begin
      next_pc = predicted_pc;
    end
  end

  assign ram_rd_addr = cfg_run_i ? next_pc : cfg_addr_i;

  always_ff @(posedge clk_i) begin
    if (cfg_w_v_i) begin
      ucode_ram[cfg_addr_i] <= cfg_data_i;
    end
    ram_rd_data <= ucode_ram[ram_rd_addr];
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || !cfg_run_i) begin
      fetch_pc_r <= '0;
      fetch_v_r  <= 1'b0;
    end else begin
      fetch_pc_r <= next_pc;
      fetch_v_r  <= 1'b1;
    end
  end

  // Fetched word is dropped on a mispredict
  always_ff @(posedge clk_i) begin
    if (rst_i || !cfg_run_i) begin
      ex_v_r <= 1'b0;
    end else if (!stall) begin
      ex_v_r <= fetch_v_r & ~mispredict_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      ex_inst_r <= fetch_inst;
      ex_pc_r   <= fetch_pc_r;
    end
  end

  assign cfg_ucode_data_o = ram_rd_data;
  assign inst_o           = ex_inst_r;
  assign inst_v_o         = ex_v_r;
  assign ex_pc_o          = ex_pc_r;

endmodule

`default_nettype wire

/* design/cce_alu_branch.sv */
// ALU and branch resolution; all compares are unsigned, SHR uses only the low 4 bits of operand B
`default_nettype none

`include "cce_config.svh"

module cce_alu_branch
  import cce_inst_pkg::*;
  (input  wire cce_inst_u                inst_i
   , input  wire                         inst_v_i
   , input  wire [`CCE_PC_WIDTH-1:0]     ex_pc_i
   , input  wire [`CCE_GPR_WIDTH-1:0]    src_a_i
   , input  wire [`CCE_GPR_WIDTH-1:0]    src_b_i
   , output logic [`CCE_GPR_WIDTH-1:0]   alu_res_o
   , output logic                        mispredict_o
   , output logic [`CCE_PC_WIDTH-1:0]    branch_pc_o
   );

  logic [`CCE_GPR_WIDTH-1:0] opd_b;
  logic                      is_branch;
  logic                      taken;
  logic                      predicted;

  assign opd_b = inst_i.op.use_imm ? inst_i.op.imm : src_b_i;

  always_comb begin
    case (inst_i.op.opcode)
      e_op_add:  alu_res_o = src_a_i + opd_b;
      e_op_sub:  alu_res_o = src_a_i - opd_b;
      e_op_and:  alu_res_o = src_a_i & opd_b;
      e_op_or:   alu_res_o = src_a_i | opd_b;
      e_op_shr:  alu_res_o = src_a_i >> opd_b[3:0];
      e_op_movi: alu_res_o = inst_i.op.imm;
      default:   alu_res_o = '0;
    endcase
  end

  // Branch outcome seen through the branch format
  always_comb begin
    is_branch = 1'b1;
    taken     = 1'b0;
    case (inst_i.br.opcode)
      e_op_beq: taken = (src_a_i == src_b_i);
      e_op_bne: taken = (src_a_i != src_b_i);
      e_op_blt: taken = (src_a_i < src_b_i);
      e_op_jmp: taken = 1'b1;
      default:  is_branch = 1'b0;
    endcase
  end

  // JMP was always taken by predecode
  assign predicted    = (inst_i.br.opcode == e_op_jmp) | inst_i.br.predict_taken;
  assign mispredict_o = inst_v_i & is_branch & (taken != predicted);
  assign branch_pc_o  = taken ? inst_i.br.target : ex_pc_i + `CCE_PC_WIDTH'(1);

endmodule

`default_nettype wire

/* design/cce_msg.sv */
// Message unit; one command buffer entry only, a full buffer that is not draining stalls PUSHC
`default_nettype none

`include "cce_config.svh"

module cce_msg
  import cce_inst_pkg::*;
  import cce_msg_pkg::*;
  (input  wire                          clk_i
   , input  wire                        rst_i
   , input  wire cce_inst_u             inst_i
   , input  wire                        inst_v_i
   , input  wire [`CCE_GPR_WIDTH-1:0]   cmd_word_i
   , input  wire cce_lce_req_s          lce_req_i
   , input  wire                        lce_req_v_i
   , input  wire                        lce_cmd_ready_i
   , output logic                       lce_req_yumi_o
   , output cce_lce_req_s               pop_data_o
   , output logic                       pop_stall_o
   , output logic                       push_stall_o
   , output cce_lce_cmd_s               lce_cmd_o
   , output logic                       lce_cmd_v_o
   );

  logic         is_pop;
  logic         is_push;
  logic         buf_free;
  logic         push;
  logic         cmd_v_r;
  cce_lce_cmd_s cmd_r;

  assign is_pop  = inst_v_i & (inst_i.op.opcode == e_op_popq);
  assign is_push = inst_v_i & (inst_i.op.opcode == e_op_pushc);

  // Request side
  assign lce_req_yumi_o = is_pop & lce_req_v_i;
  assign pop_stall_o    = is_pop & ~lce_req_v_i;
  assign pop_data_o     = lce_req_i;

  // Buffer takes a word when empty or emptying this cycle
  assign buf_free     = ~cmd_v_r | lce_cmd_ready_i;
  assign push         = is_push & buf_free;
  assign push_stall_o = is_push & ~buf_free;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cmd_v_r <= 1'b0;
    end else if (push) begin
      cmd_v_r <= 1'b1;
    end else if (lce_cmd_ready_i) begin
      cmd_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      cmd_r <= cce_lce_cmd_s'(cmd_word_i);
    end
  end

  assign lce_cmd_o   = cmd_r;
  assign lce_cmd_v_o = cmd_v_r;

endmodule

`default_nettype wire

/* design/cce_pending.sv */
// Pending bits per way group; a PSET is visible to a PRD in the next cycle, not the same one
`default_nettype none

`include "cce_config.svh"

module cce_pending
  import cce_inst_pkg::*;
  (input  wire                          clk_i
   , input  wire                        rst_i
   , input  wire cce_inst_u             inst_i
   , input  wire                        inst_v_i
   , input  wire [`CCE_ADDR_WIDTH-1:0]  addr_i
   , output logic                       pending_o
   );

  logic [2**`CCE_LG_WAY_GROUPS-1:0]  pending_r;
  logic [`CCE_LG_WAY_GROUPS-1:0]     way_group;

  assign way_group = addr_i[`CCE_BLOCK_OFFSET +: `CCE_LG_WAY_GROUPS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_r <= '0;
    end else if (inst_v_i) begin
      if (inst_i.op.opcode == e_op_pset) begin
        pending_r[way_group] <= 1'b1;
      end else if (inst_i.op.opcode == e_op_pclr) begin
        pending_r[way_group] <= 1'b0;
      end
    end
  end

  // Read for PRD
  assign pending_o = pending_r[way_group];

endmodule

`default_nettype wire

/* design/cce_regs.sv */
// GPR file; branches name their sources in different bits than other instructions
`default_nettype none

`include "cce_config.svh"

module cce_regs
  import cce_inst_pkg::*;
  import cce_msg_pkg::*;
  (input  wire                          clk_i
   , input  wire                        rst_i
   , input  wire cce_inst_u             inst_i
   , input  wire                        inst_v_i
   , input  wire                        exec_stall_i
   , input  wire [`CCE_GPR_WIDTH-1:0]   alu_res_i
   , input  wire cce_lce_req_s          pop_data_i
   , input  wire                        pending_i
   , output logic [`CCE_GPR_WIDTH-1:0]  src_a_o
   , output logic [`CCE_GPR_WIDTH-1:0]  src_b_o
   );

  logic [`CCE_GPR_WIDTH-1:0]     gpr_r [`CCE_NUM_GPR];
  logic [`CCE_GPR_SEL_WIDTH-1:0] sel_a;
  logic [`CCE_GPR_SEL_WIDTH-1:0] sel_b;
  logic                          is_branch;
  logic                          retire;

  assign is_branch = inst_i.br.opcode inside {e_op_beq, e_op_bne, e_op_blt, e_op_jmp};
  assign sel_a     = is_branch ? inst_i.br.src_a : inst_i.op.src_a;
  assign sel_b     = is_branch ? inst_i.br.src_b : inst_i.op.src_b;
  assign src_a_o   = gpr_r[sel_a];
  assign src_b_o   = gpr_r[sel_b];

  assign retire = inst_v_i & ~exec_stall_i;

  // Write-back source chosen by opcode
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpr_r <= '{default: '0};
    end else if (retire) begin
      case (inst_i.op.opcode)
        e_op_add, e_op_sub, e_op_and, e_op_or, e_op_shr, e_op_movi:
          gpr_r[inst_i.op.dst] <= alu_res_i;
        e_op_popq: gpr_r[inst_i.op.dst] <= pop_data_i;
        e_op_prd:  gpr_r[inst_i.op.dst] <= {{(`CCE_GPR_WIDTH-1){1'b0}}, pending_i};
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/cce_top.sv */
// Engine top; microcode must be loaded while cfg_run_i is low, protocol policy is all in microcode
`default_nettype none

`include "cce_config.svh"

module cce_top
  import cce_inst_pkg::*;
  import cce_msg_pkg::*;
  (input  wire                          clk_i
   , input  wire                        rst_i

   // Configuration port
   , input  wire                        cfg_run_i
   , input  wire                        cfg_w_v_i
   , input  wire [`CCE_PC_WIDTH-1:0]    cfg_addr_i
   , input  wire [`CCE_INST_WIDTH-1:0]  cfg_data_i
   , output logic [`CCE_INST_WIDTH-1:0] cfg_ucode_data_o

   // LCE request, valid/yumi
   , input  wire cce_lce_req_s          lce_req_i
   , input  wire                        lce_req_v_i
   , output logic                       lce_req_yumi_o

   // LCE command, valid/ready
   , output cce_lce_cmd_s               lce_cmd_o
   , output logic                       lce_cmd_v_o
   , input  wire                        lce_cmd_ready_i
   );

  // Execute stage instruction
  cce_inst_u                   inst;
  logic                        inst_v;
  logic [`CCE_PC_WIDTH-1:0]    ex_pc;

  // Operands and results
  logic [`CCE_GPR_WIDTH-1:0]   src_a;
  logic [`CCE_GPR_WIDTH-1:0]   src_b;
  logic [`CCE_GPR_WIDTH-1:0]   alu_res;
  logic                        pending;
  cce_lce_req_s                pop_data;

  // Branch repair and back-pressure
  logic                        mispredict;
  logic [`CCE_PC_WIDTH-1:0]    branch_pc;
  logic                        pop_stall;
  logic                        push_stall;
  logic                        exec_stall;

  assign exec_stall = pop_stall | push_stall;

  cce_ctrl ctrl
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.cfg_run_i(cfg_run_i)
     ,.cfg_w_v_i(cfg_w_v_i)
     ,.cfg_addr_i(cfg_addr_i)
     ,.cfg_data_i(cfg_data_i)
     ,.mispredict_i(mispredict)
     ,.branch_pc_i(branch_pc)
     ,.pop_stall_i(pop_stall)
     ,.push_stall_i(push_stall)
     ,.cfg_ucode_data_o(cfg_ucode_data_o)
     ,.inst_o(inst)
     ,.inst_v_o(inst_v)
     ,.ex_pc_o(ex_pc)
     );

  cce_alu_branch alu_branch
    (.inst_i(inst)
     ,.inst_v_i(inst_v)
     ,.ex_pc_i(ex_pc)
     ,.src_a_i(src_a)
     ,.src_b_i(src_b)
     ,.alu_res_o(alu_res)
     ,.mispredict_o(mispredict)
     ,.branch_pc_o(branch_pc)
     );

  cce_regs regs
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.inst_i(inst)
     ,.inst_v_i(inst_v)
     ,.exec_stall_i(exec_stall)
     ,.alu_res_i(alu_res)
     ,.pop_data_i(pop_data)
     ,.pending_i(pending)
     ,.src_a_o(src_a)
     ,.src_b_o(src_b)
     );

  // Address lives in the low bits of the GPR
  cce_pending pending_bits
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.inst_i(inst)
     ,.inst_v_i(inst_v)
     ,.addr_i(src_a[`CCE_ADDR_WIDTH-1:0])
     ,.pending_o(pending)
     );

  cce_msg msg
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.inst_i(inst)
     ,.inst_v_i(inst_v)
     ,.cmd_word_i(src_a)
     ,.lce_req_i(lce_req_i)
     ,.lce_req_v_i(lce_req_v_i)
     ,.lce_cmd_ready_i(lce_cmd_ready_i)
     ,.lce_req_yumi_o(lce_req_yumi_o)
     ,.pop_data_o(pop_data)
     ,.pop_stall_o(pop_stall)
     ,.push_stall_o(push_stall)
     ,.lce_cmd_o(lce_cmd_o)
     ,.lce_cmd_v_o(lce_cmd_v_o)
     );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module cce_tb

status=0
out=$(./obj_dir/Vcce_tb) || status=$?
echo "$out"

if [ "$status" -eq 0 ] && grep -qx "Test OK" <<< "$out"; then
  exit 0
else
  exit 1
fi

/* verif/cce_stimulus.txt */
// Header at 00: microcode count, request count, command count
// Microcode from 08, request words from 40, expected command words from 60
@00
0000001c 00000007 00000007
@08
5c200000 a0000000 0f200020 442001c0 58200060 66280000 e4000000 58200000
76240000 c0000000 442001c0 58200000 66200000 2427ffe0 35280000 902c0000
2427ffe0 902c0000 34380000 902c0000 d0000000 902e0000 b1000000 582000e0
7e820000 37300000 b1000000 90360000
// READ, WRITE same group, EVICT, WRITE again, UPGRADE, READ, READ to a pending group
@40
00001104 00006204 0000d104 00006204 0000b018 000003f0 00001118
// Grants and NACKs in order, then the count word built after the loop exit
@60
00001104 0000e204 00006204 00007018 000003f0 0000d118 00008007

/* verif/cce_tb.sv */
// Testbench for cce_top; run from the project root so the stimulus path resolves
`default_nettype none

`include "cce_config.svh"

module cce_tb
  import cce_msg_pkg::*;
  ();

  logic                        clk_i;
  logic                        rst_i;
  logic                        cfg_run_i;
  logic                        cfg_w_v_i;
  logic [`CCE_PC_WIDTH-1:0]    cfg_addr_i;
  logic [`CCE_INST_WIDTH-1:0]  cfg_data_i;
  logic [`CCE_INST_WIDTH-1:0]  cfg_ucode_data_o;
  cce_lce_req_s                lce_req_i;
  logic                        lce_req_v_i;
  logic                        lce_req_yumi_o;
  cce_lce_cmd_s                lce_cmd_o;
  logic                        lce_cmd_v_o;
  logic                        lce_cmd_ready_i;

  logic [31:0] stim [0:127];
  int          n_ucode;
  int          n_req;
  int          n_cmd;
  int          req_idx;
  int          cmd_idx;
  int          cycles;
  integer      seed;
  logic [31:0] rnd;
  logic        prev_v;
  logic        prev_ready;
  logic [15:0] prev_cmd;

  cce_top uut
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.cfg_run_i(cfg_run_i)
     ,.cfg_w_v_i(cfg_w_v_i)
     ,.cfg_addr_i(cfg_addr_i)
     ,.cfg_data_i(cfg_data_i)
     ,.cfg_ucode_data_o(cfg_ucode_data_o)
     ,.lce_req_i(lce_req_i)
     ,.lce_req_v_i(lce_req_v_i)
     ,.lce_req_yumi_o(lce_req_yumi_o)
     ,.lce_cmd_o(lce_cmd_o)
     ,.lce_cmd_v_o(lce_cmd_v_o)
     ,.lce_cmd_ready_i(lce_cmd_ready_i)
     );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic require_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Failure at time %0t: %s", $time, what);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // Nothing may leave the engine while it is held, even with a request on offer
  task automatic expect_idle();
    compare_value("lce_req_yumi_o", {31'b0, lce_req_yumi_o}, 32'h0);
    compare_value("lce_cmd_v_o", {31'b0, lce_cmd_v_o}, 32'h0);
  endtask

  // One clock of running traffic with handshakes judged just after the falling edge
  task automatic run_cycle();
    @(negedge clk_i);
    rnd = $random(seed);
    lce_cmd_ready_i = (rnd[1:0] != 2'b00);
    if (req_idx < n_req) begin
      lce_req_v_i = 1'b1;
      lce_req_i   = cce_lce_req_s'(stim['h40 + req_idx][15:0]);
    end else begin
      lce_req_v_i = 1'b0;
      lce_req_i   = '0;
    end
    #1;
    if (prev_v && !prev_ready) begin
      require_true(lce_cmd_v_o, "command valid dropped before it was accepted");
      compare_value("lce_cmd_o", {16'h0, lce_cmd_o}, {16'h0, prev_cmd});
    end
    if (lce_req_yumi_o) begin
      require_true(lce_req_v_i, "request yumi raised without a valid request");
      req_idx++;
    end
    if (lce_cmd_v_o && lce_cmd_ready_i) begin
      require_true(cmd_idx < n_cmd, "an extra LCE command was sent");
      compare_value("lce_cmd_o", {16'h0, lce_cmd_o}, stim['h60 + cmd_idx]);
      cmd_idx++;
    end
    prev_v     = lce_cmd_v_o;
    prev_ready = lce_cmd_ready_i;
    prev_cmd   = lce_cmd_o;
  endtask

  initial begin
    seed            = 32'h7379_1361;
    rst_i           = 1'b1;
    cfg_run_i       = 1'b0;
    cfg_w_v_i       = 1'b0;
    cfg_addr_i      = '0;
    cfg_data_i      = '0;
    lce_req_i       = '0;
    lce_req_v_i     = 1'b0;
    lce_cmd_ready_i = 1'b0;
    prev_v          = 1'b0;
    prev_ready      = 1'b0;
    prev_cmd        = '0;
    $readmemh("verif/cce_stimulus.txt", stim);
    n_ucode = stim[0];
    n_req   = stim[1];
    n_cmd   = stim[2];

    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;

    // First request waits on the port while the engine is held
    lce_req_v_i = 1'b1;
    lce_req_i   = cce_lce_req_s'(stim['h40][15:0]);

    // Load the microcode program
    for (int i = 0; i < n_ucode; i++) begin
      cfg_w_v_i  = 1'b1;
      cfg_addr_i = i[`CCE_PC_WIDTH-1:0];
      cfg_data_i = stim[8 + i];
      @(negedge clk_i);
      expect_idle();
    end
    cfg_w_v_i = 1'b0;

    // Readback data follows the address by one cycle
    for (int i = 0; i < n_ucode; i++) begin
      cfg_addr_i = i[`CCE_PC_WIDTH-1:0];
      @(negedge clk_i);
      compare_value("cfg_ucode_data_o", cfg_ucode_data_o, stim[8 + i]);
      expect_idle();
    end

    cfg_run_i = 1'b1;
    req_idx   = 0;
    cmd_idx   = 0;
    cycles    = 0;
    while (cmd_idx < n_cmd) begin
      run_cycle();
      cycles++;
      require_true(cycles < 2000, "timed out waiting for LCE commands");
    end

    // Quiet tail catches late duplicates and extra pops
    for (int i = 0; i < 20; i++) begin
      run_cycle();
    end
    compare_value("requests consumed", req_idx, n_req);

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
